// File: mixer_cfg.svh
`ifndef MIXER_CFG_SVH
`define MIXER_CFG_SVH

// matrix size
`define MIX_CHANNELS	8		// source channels and mix buses
`define MIX_PAIRS		4		// stereo codec outputs

// data widths
`define SAMPLE_W		16
`define GAIN_W			8

// gain after reset gives input/16 on every crosspoint
`define GAIN_RESET		8'h80

// top two command bits of a gain load
`define CMD_GAIN_TAG	2'b11

// right shift for gain bit 7, bit 0 gets this plus 7
`define GAIN_TOP_SHIFT	4

`endif

// File: mixer_pkg.sv
`include "mixer_cfg.svh"

package mixer_pkg;

	// audio and gain words
	typedef logic [`SAMPLE_W-1:0] sample_t;
	typedef logic [`GAIN_W-1:0] gain_t;

	// channel or bus number, minus one
	typedef logic [$clog2(`MIX_CHANNELS)-1:0] chan_idx_t;

	// host command byte
	typedef struct packed
	{
		logic [1:0] tag;		// 2'b11 marks a gain load
		chan_idx_t bus;			// destination mix bus
		chan_idx_t src;			// source channel
	} cmd_t;

	// one sample per channel
	typedef sample_t [`MIX_CHANNELS-1:0] sample_vec_t;

	// gains into one bus, by source
	typedef gain_t [`MIX_CHANNELS-1:0] gain_row_t;

	// full crosspoint matrix, by bus
	typedef gain_row_t [`MIX_CHANNELS-1:0] gain_matrix_t;

	// the two buses behind one codec output
	typedef struct packed
	{
		sample_t left;
		sample_t right;
	} pair_mix_t;

	typedef pair_mix_t [`MIX_PAIRS-1:0] pair_vec_t;

	// codec output words
	typedef sample_t [`MIX_PAIRS-1:0] out_vec_t;

endpackage

// File: gain_scale.sv
`timescale 1ns/1ps
`include "mixer_cfg.svh"

module gain_scale
(
	input mixer_pkg::sample_t sample,
	input mixer_pkg::gain_t gain,
	output mixer_pkg::sample_t scaled
);

	// shift used for gain bit 0
	localparam int BOT_SHIFT = `GAIN_TOP_SHIFT + `GAIN_W - 1;

	mixer_pkg::sample_t terms [`GAIN_W];	// one partial term per gain bit
	mixer_pkg::sample_t sum;

	genvar k;

	// gain bit k adds sample >> (BOT_SHIFT - k)
	generate
		for (k = 0; k < `GAIN_W; k++)
		begin : g_term
			assign terms[k] = gain[k] ? (sample >> (BOT_SHIFT - k)) : '0;
		end
	endgenerate

	// add up the partial terms, no multiplier
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < `GAIN_W; i++)
		begin
			sum = sum + terms[i];
		end
	end

	assign scaled = sum;

endmodule

// File: mix_bus.sv
`timescale 1ns/1ps
`include "mixer_cfg.svh"

module mix_bus
(
	input mixer_pkg::sample_vec_t samples,	// all source channels
	input mixer_pkg::gain_row_t gains,		// gains into this bus
	output mixer_pkg::sample_t mix
);

	mixer_pkg::sample_t scaled [`MIX_CHANNELS];
	mixer_pkg::sample_t acc;

	genvar s;

	// one crosspoint per source channel
	generate
		for (s = 0; s < `MIX_CHANNELS; s++)
		begin : g_xpt
			gain_scale u_scale
			(
				.sample(samples[s]),
				.gain(gains[s]),
				.scaled(scaled[s])
			);
		end
	endgenerate

	// bus sum wraps at sample width
	always_comb
	begin
		acc = '0;
		for (int i = 0; i < `MIX_CHANNELS; i++)
		begin
			acc = acc + scaled[i];
		end
	end

	assign mix = acc;

endmodule

// File: gain_regs.sv
`timescale 1ns/1ps
`include "mixer_cfg.svh"

module gain_regs
(
	input logic clk,
	input logic nRst,
	input logic wr_en,						// host write strobe
	input logic cmd_data_sw,				// 1 command, 0 data
	input logic [7:0] data,
	output mixer_pkg::gain_matrix_t gains
);

	mixer_pkg::cmd_t cmd_r;					// last command byte

	logic cmd_wr;
	logic data_wr;
	logic gain_cmd;
	logic gain_wr;

	// host strobe decode
	assign cmd_wr = wr_en & cmd_data_sw;
	assign data_wr = wr_en & ~cmd_data_sw;

	// only a gain tag lets a data byte through
	assign gain_cmd = (cmd_r.tag == `CMD_GAIN_TAG);
	assign gain_wr = data_wr & gain_cmd;

	// command register
	// stays in force for any number of data writes
	always_ff @(posedge clk or negedge nRst)
	begin
		if (!nRst)
		begin
			cmd_r <= '0;					// tag 00, not a gain load
		end
		else if (cmd_wr)
		begin
			cmd_r <= mixer_pkg::cmd_t'(data);
		end
	end

	// crosspoint gain matrix
	always_ff @(posedge clk or negedge nRst)
	begin
		if (!nRst)
		begin
			for (int b = 0; b < `MIX_CHANNELS; b++)
			begin
				for (int s = 0; s < `MIX_CHANNELS; s++)
				begin
					gains[b][s] <= `GAIN_RESET;
				end
			end
		end
		else if (gain_wr)
		begin
			// address comes from the command held before this edge
			gains[cmd_r.bus][cmd_r.src] <= data;
		end
	end

	// host strobes must be clean once out of reset
	assert property (@(posedge clk) disable iff (!nRst)
		!$isunknown({wr_en, cmd_data_sw}))
		else $error("gain_regs: unknown value on host write strobes");

endmodule

// File: frame_latch.sv
`timescale 1ns/1ps
`include "mixer_cfg.svh"

module frame_latch
(
	input logic clk,
	input logic nRst,
	input logic ws,							// codec word select
	input mixer_pkg::pair_vec_t pairs,
	output mixer_pkg::out_vec_t codec_out
);

	logic ws_d;								// ws one clock back
	logic ws_edge;
	logic load_left;
	logic load_right;

	// edge seen at the same clock that samples the new ws level
	assign ws_edge = ws ^ ws_d;
	assign load_left = ws_edge & ~ws;		// falling ws
	assign load_right = ws_edge & ws;		// rising ws

	always_ff @(posedge clk or negedge nRst)
	begin
		if (!nRst)
		begin
			ws_d <= 1'b0;
		end
		else
		begin
			ws_d <= ws;
		end
	end

	// codec output words
	always_ff @(posedge clk or negedge nRst)
	begin
		if (!nRst)
		begin
			codec_out <= '0;
		end
		else if (load_left)
		begin
			for (int p = 0; p < `MIX_PAIRS; p++)
			begin
				codec_out[p] <= pairs[p].left;	// buses 1, 3, 5, 7
			end
		end
		else if (load_right)
		begin
			for (int p = 0; p < `MIX_PAIRS; p++)
			begin
				codec_out[p] <= pairs[p].right;	// buses 2, 4, 6, 8
			end
		end
	end

	// outputs only move on a ws edge
	assert property (@(posedge clk) disable iff (!nRst)
		(ws == ws_d) |=> $stable(codec_out))
		else $error("frame_latch: codec_out changed without a ws edge");

endmodule

// File: mixer_top.sv
`timescale 1ns/1ps
`include "mixer_cfg.svh"

module mixer_top
(
	input logic clk,
	input logic nRst,
	input logic wr_en,
	input logic cmd_data_sw,
	input logic [7:0] data,
	input logic ws,
	input mixer_pkg::sample_vec_t codec_in,
	output mixer_pkg::out_vec_t codec_out
);

	mixer_pkg::gain_matrix_t gains;
	mixer_pkg::sample_vec_t bus_mix;		// one word per mix bus
	mixer_pkg::pair_vec_t pairs;

	genvar b;
	genvar p;

	// host port and crosspoint gains
	gain_regs u_gain_regs
	(
		.clk(clk),
		.nRst(nRst),
		.wr_en(wr_en),
		.cmd_data_sw(cmd_data_sw),
		.data(data),
		.gains(gains)
	);

	// mix buses, combinational from gains and codec_in
	generate
		for (b = 0; b < `MIX_CHANNELS; b++)
		begin : g_bus
			mix_bus u_mix_bus
			(
				.samples(codec_in),
				.gains(gains[b]),
				.mix(bus_mix[b])
			);
		end
	endgenerate

	// even bus is left, odd bus is right
	generate
		for (p = 0; p < `MIX_PAIRS; p++)
		begin : g_pair
			assign pairs[p].left = bus_mix[2*p];
			assign pairs[p].right = bus_mix[2*p+1];
		end
	endgenerate

	frame_latch u_frame_latch
	(
		.clk(clk),
		.nRst(nRst),
		.ws(ws),
		.pairs(pairs),
		.codec_out(codec_out)
	);

endmodule

// File: tb_mixer.sv
`timescale 1ns/1ps
`include "mixer_cfg.svh"

module tb_mixer;

	localparam int LOAD_TIMEOUT = 10;		// cycles allowed for a ws load
	localparam int STRESS_FRAMES = 200;

	logic clk = 1'b0;
	logic nRst;
	logic wr_en;
	logic cmd_data_sw;
	logic [7:0] data;
	logic ws;
	mixer_pkg::sample_vec_t codec_in;
	mixer_pkg::out_vec_t codec_out;

	// reference state, gains indexed by bus then source
	logic [7:0][7:0][7:0] model_gain;
	logic [7:0] model_cmd;

	mixer_pkg::out_vec_t exp_out;
	mixer_pkg::out_vec_t last_out = '0;
	logic ws_seen = 1'b0;					// ws as the DUT last sampled it
	logic pending = 1'b0;
	int frames_checked = 0;
	int check_count = 0;
	int error_count = 0;
	logic [31:0] rng_state = 32'd49;

	mixer_top uut
	(
		.clk(clk),
		.nRst(nRst),
		.wr_en(wr_en),
		.cmd_data_sw(cmd_data_sw),
		.data(data),
		.ws(ws),
		.codec_in(codec_in),
		.codec_out(codec_out)
	);

	always #2 clk = ~clk;

	function automatic logic [15:0] rand_bits();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	// bit k of a gain adds the input shifted right by 11 - k
	function automatic logic [15:0] model_mix(input int bus, input logic [7:0][15:0] inputs,
		input logic [7:0][7:0][7:0] gains);
		logic [15:0] acc;
		logic [7:0] g;
		acc = '0;
		for (int s = 0; s < 8; s++)
		begin
			g = gains[bus][s];
			for (int k = 0; k < 8; k++)
			begin
				if (g[k])
					acc = acc + (inputs[s] >> (11 - k));
			end
		end
		return acc;
	endfunction

	task automatic check(input logic [15:0] got, input logic [15:0] exp, input string msg);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// compares at mid cycle, one cycle after a ws change is sampled
	always @(negedge clk)
	begin
		if (nRst)
		begin
			if (pending)
			begin
				for (int p = 0; p < `MIX_PAIRS; p++)
					check(codec_out[p], exp_out[p], $sformatf("pair %0d after ws edge", p));
				pending = 1'b0;
				frames_checked++;
			end
			else
			begin
				for (int p = 0; p < `MIX_PAIRS; p++)
					check(codec_out[p], last_out[p], $sformatf("pair %0d held", p));
			end
			if (ws !== ws_seen)
			begin
				for (int p = 0; p < `MIX_PAIRS; p++)
					exp_out[p] = model_mix(ws ? 2*p+1 : 2*p, codec_in, model_gain);
				pending = 1'b1;
				ws_seen = ws;
			end
			last_out = codec_out;
		end
	end

	// drives one host byte, model follows at the sampling edge
	task automatic host_write(input logic is_cmd, input logic [7:0] value);
		wr_en = 1'b1;
		cmd_data_sw = is_cmd;
		data = value;
		@(posedge clk);
		if (is_cmd)
			model_cmd = value;
		else if (model_cmd[7:6] == 2'b11)
			model_gain[model_cmd[5:3]][model_cmd[2:0]] = value;
		#1;
		wr_en = 1'b0;
	endtask

	task automatic set_gain(input int bus, input int src, input logic [7:0] value);
		host_write(1'b1, {2'b11, 3'(bus), 3'(src)});
		host_write(1'b0, value);
	endtask

	task automatic toggle_ws();
		int start;
		int waited;
		start = frames_checked;
		waited = 0;
		ws = ~ws;
		while (frames_checked == start && waited < LOAD_TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (frames_checked == start)
		begin
			$display("timeout: codec_out was never checked after ws toggle at %0t", $time);
			$display("Simulation FAILED");
			$finish;
		end
		#1;
	endtask

	task automatic randomize_inputs(input logic allow_large);
		logic [15:0] r;
		for (int s = 0; s < `MIX_CHANNELS; s++)
		begin
			r = rand_bits();
			codec_in[s] = (allow_large && r[0]) ? (r | 16'hf000) : r;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		$display("test %0d %s: %s", num, name, (error_count == err_start) ? "ok" : "errors");
	endtask

	task automatic test_reset_defaults();
		int err_start;
		logic [15:0] sum;
		err_start = error_count;
		for (int p = 0; p < `MIX_PAIRS; p++)
			check(codec_out[p], 16'h0000, "output after reset");
		randomize_inputs(1'b0);
		sum = '0;
		for (int s = 0; s < `MIX_CHANNELS; s++)
			sum = sum + (codec_in[s] >> 4);	// every gain is 80
		toggle_ws();
		for (int p = 0; p < `MIX_PAIRS; p++)
			check(codec_out[p], sum, "default gain mix");
		toggle_ws();
		report_test(1, "reset defaults", err_start);
	endtask

	task automatic test_single_route();
		int err_start;
		logic [7:0] vals [4];
		err_start = error_count;
		vals[0] = 8'h01;
		vals[1] = 8'h20;
		vals[2] = 8'hff;
		vals[3] = 8'h10;
		for (int i = 0; i < 4; i++)
		begin
			set_gain(2*i + (i % 2), 7 - i, vals[i]);
			randomize_inputs(1'b1);
			toggle_ws();
			toggle_ws();
		end
		report_test(2, "single crosspoint", err_start);
	endtask

	task automatic test_cmd_rules();
		int err_start;
		err_start = error_count;
		host_write(1'b1, 8'b01_011_010);	// not a gain tag
		host_write(1'b0, 8'h00);
		host_write(1'b1, 8'b10_000_000);
		host_write(1'b0, 8'h55);
		toggle_ws();
		toggle_ws();
		host_write(1'b1, 8'b11_010_101);
		host_write(1'b0, 8'h40);
		host_write(1'b0, 8'h22);
		host_write(1'b0, 8'h7f);			// last one sticks
		toggle_ws();
		toggle_ws();
		host_write(1'b1, 8'b11_110_001);	// command alone
		toggle_ws();
		toggle_ws();
		report_test(3, "command rules", err_start);
	endtask

	task automatic test_left_right();
		int err_start;
		err_start = error_count;
		for (int b = 0; b < `MIX_CHANNELS; b++)
			for (int s = 0; s < `MIX_CHANNELS; s++)
				set_gain(b, s, 8'(b * 37 + s * 11 + 5));
		for (int i = 0; i < 4; i++)
		begin
			randomize_inputs(1'b0);
			toggle_ws();
		end
		report_test(4, "left right select", err_start);
	endtask

	task automatic test_hold();
		int err_start;
		err_start = error_count;
		toggle_ws();
		for (int i = 0; i < 6; i++)
		begin
			randomize_inputs(1'b1);
			set_gain(i, 7 - i, 8'hc3);		// no ws edge, outputs must hold
		end
		toggle_ws();
		report_test(5, "hold between frames", err_start);
	endtask

	task automatic test_stress();
		int err_start;
		int idle;
		logic [15:0] r;
		err_start = error_count;
		for (int f = 0; f < STRESS_FRAMES; f++)
		begin
			r = rand_bits();
			if (r[0])
				host_write(1'b1, {(r[2:1] == 2'b00) ? r[4:3] : 2'b11, r[7:5], r[10:8]});
			if (r[11])
				host_write(1'b0, 8'(rand_bits()));
			randomize_inputs(1'b1);
			idle = int'(rand_bits() % 16'd6);
			for (int i = 0; i < idle; i++)
			begin
				@(posedge clk);
				#1;
				randomize_inputs(1'b1);
			end
			toggle_ws();
		end
		report_test(6, "random stress", err_start);
	endtask

	initial
	begin
		nRst = 1'b0;
		wr_en = 1'b0;
		cmd_data_sw = 1'b0;
		data = 8'h00;
		ws = 1'b0;
		codec_in = '0;
		model_cmd = 8'h00;
		for (int b = 0; b < 8; b++)
			for (int s = 0; s < 8; s++)
				model_gain[b][s] = 8'h80;
		repeat (10) @(posedge clk);
		#1;
		nRst = 1'b1;
		@(posedge clk);
		#1;
		test_reset_defaults();
		test_single_route();
		test_cmd_rules();
		test_left_right();
		test_hold();
		test_stress();
		$display("done: %0d checks, %0d errors, %0d frames", check_count, error_count,
			frames_checked);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+.
mixer_pkg.sv
gain_scale.sv
mix_bus.sv
gain_regs.sv
frame_latch.sv
mixer_top.sv
tb_mixer.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mixer
VFLAGS ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f list.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
